/* glb_cfg.svh */
// Sizing of the global buffer processor path.
// GLB_TILE_SEL_WIDTH must be the base-2 log of GLB_NUM_TILES.
// The global word address is the tile select on top of the bank word address.
// Data width must be a whole number of bytes.

`ifndef GLB_CFG_SVH
`define GLB_CFG_SVH

// tiles in the west to east chain
`define GLB_NUM_TILES 4

// tile select bits at the top of the global address
`define GLB_TILE_SEL_WIDTH 2

// word address inside one bank
`define GLB_BANK_ADDR_WIDTH 8

// one bank word
`define GLB_BANK_DATA_WIDTH 64

`endif

/* glb_map_pkg.sv */
// Address map of the global buffer as seen by the processor.
// Word addressed only; there are no byte offsets in the address.
// The tile select sits in the upper bits, so consecutive words stay in
// one tile and only the top bits move a request to another tile.

package glb_map_pkg;

`include "glb_cfg.svh"

    // which tile owns the word
    typedef logic [`GLB_TILE_SEL_WIDTH-1:0] tile_sel_t;

    // word index inside one bank
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // global word address, tile select on top
    typedef struct packed {
        tile_sel_t  tile;
        bank_addr_t word;
    } glb_addr_t;

    // one write enable per byte of a bank word
    typedef logic [`GLB_BANK_DATA_WIDTH/8-1:0] strb_t;

endpackage

/* glb_pkt_pkg.sv */
// Packet contents that travel along the tile chain.
// One packet per stage per cycle, no back-pressure anywhere.
// PKT_IDLE marks an empty slot; read responses ride on the PKT_RD packet
// that requested them.

package glb_pkt_pkg;

`include "glb_cfg.svh"

    // request kind carried by a packet
    typedef enum logic [1:0] {
        PKT_IDLE = 2'd0,
        PKT_WR   = 2'd1,
        PKT_RD   = 2'd2
    } pkt_op_t;

    // one bank word, write payload and read data alike
    typedef logic [`GLB_BANK_DATA_WIDTH-1:0] bank_data_t;

endpackage

/* glb_packet_if.sv */
// One packet hop between neighboring stages of the tile chain.
// The src side always drives from a register, so a hop is one cycle.
// rd_data is only meaningful while rd_valid is high.

`timescale 1ns/1ps

interface glb_packet_if import glb_map_pkg::*, glb_pkt_pkg::*; ();

    pkt_op_t    op;
    strb_t      strb;
    glb_addr_t  addr;
    // write payload
    bank_data_t data;
    // read response picked up by the owning tile
    bank_data_t rd_data;
    logic       rd_valid;

    modport src (
        output op,
        output strb,
        output addr,
        output data,
        output rd_data,
        output rd_valid
    );

    modport dst (
        input op,
        input strb,
        input addr,
        input data,
        input rd_data,
        input rd_valid
    );

endinterface

/* glb_proc_ingress.sv */
// Processor request register at the west end of the tile chain.
// wr_en and rd_en are single-cycle strobes and must never be high together.
// A request sampled at one edge is on pkt_out right after that edge.
// No back-pressure: every cycle may carry a new request.

`timescale 1ns/1ps

module glb_proc_ingress import glb_map_pkg::*; import glb_pkt_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  strb_t      wr_strb,
    input  glb_addr_t  wr_addr,
    input  bank_data_t wr_data,
    input  logic       rd_en,
    input  glb_addr_t  rd_addr,
    glb_packet_if.src  pkt_out
);

    pkt_op_t   op_next;
    glb_addr_t addr_next;
    strb_t     strb_next;

    // strobes to opcode, address follows the opcode
    always_comb begin
        if (wr_en) begin
            op_next   = PKT_WR;
            addr_next = wr_addr;
            strb_next = wr_strb;
        end else if (rd_en) begin
            op_next   = PKT_RD;
            addr_next = rd_addr;
            strb_next = '0;
        end else begin
            op_next   = PKT_IDLE;
            addr_next = rd_addr;
            strb_next = '0;
        end
    end

    // control part of the packet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_out.op       <= PKT_IDLE;
            pkt_out.rd_valid <= 1'b0;
        end else begin
            pkt_out.op       <= op_next;
            // no response exists yet at the west end
            pkt_out.rd_valid <= 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        pkt_out.strb    <= strb_next;
        pkt_out.addr    <= addr_next;
        pkt_out.data    <= wr_data;
        pkt_out.rd_data <= '0;
    end

    // a write and a read cannot share one packet
    a_no_wr_rd_overlap : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_en && rd_en)
    );

endmodule

/* glb_tile.sv */
// One global buffer tile with its bank and its packet stage.
// TILE_ID must be below GLB_NUM_TILES and unique along the chain.
// Bank is 2^GLB_BANK_ADDR_WIDTH words, byte-strobed writes, no reset on data.
// Every packet leaves one cycle after it arrives, owned or not.
// Reads load rd_data in the same stage, so the word is there on exit.

`timescale 1ns/1ps

`include "glb_cfg.svh"

module glb_tile import glb_map_pkg::*; import glb_pkt_pkg::*; #(
    parameter int TILE_ID = 0
) (
    input  logic      clk,
    input  logic      rst_n,
    glb_packet_if.dst pkt_in,
    glb_packet_if.src pkt_out
);

    localparam int BANK_DEPTH = 2 ** `GLB_BANK_ADDR_WIDTH;
    localparam int NUM_BYTES  = `GLB_BANK_DATA_WIDTH / 8;

    bank_data_t bank [BANK_DEPTH];

    glb_addr_t  in_addr;
    bank_addr_t word_addr;
    logic       tile_hit;
    logic       wr_hit;
    logic       rd_hit;

    assign in_addr   = pkt_in.addr;
    assign word_addr = in_addr.word;

    // does this tile own the packet address
    assign tile_hit = (in_addr.tile == tile_sel_t'(TILE_ID));
    assign wr_hit   = tile_hit && (pkt_in.op == PKT_WR);
    assign rd_hit   = tile_hit && (pkt_in.op == PKT_RD);

    // bank write, only strobed bytes change
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (pkt_in.strb[b]) begin
                    bank[word_addr][b*8 +: 8] <= pkt_in.data[b*8 +: 8];
                end
            end
        end
    end

    // read data, either from this bank or passed on from the west
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            pkt_out.rd_data <= bank[word_addr];
        end else begin
            pkt_out.rd_data <= pkt_in.rd_data;
        end
    end

    // control part of the forwarded packet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_out.op       <= PKT_IDLE;
            pkt_out.rd_valid <= 1'b0;
        end else begin
            pkt_out.op       <= pkt_in.op;
            pkt_out.rd_valid <= pkt_in.rd_valid | rd_hit;
        end
    end

    // request payload moves east untouched
    always_ff @(posedge clk) begin
        pkt_out.strb <= pkt_in.strb;
        pkt_out.addr <= pkt_in.addr;
        pkt_out.data <= pkt_in.data;
    end

    // a read already answered upstream cannot belong to this tile too,
    // otherwise two tiles decode the same address
    a_single_owner : assert property (
        @(posedge clk) disable iff (!rst_n)
        (pkt_in.rd_valid && pkt_in.op == PKT_RD) |-> !tile_hit
    );

endmodule

/* glb_rd_egress.sv */
// Read response register at the east end of the tile chain.
// rd_data_valid is high for one cycle per answered read, in request order.
// rd_data keeps the last returned word between responses.

`timescale 1ns/1ps

module glb_rd_egress import glb_pkt_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    glb_packet_if.dst  pkt_in,
    output bank_data_t rd_data,
    output logic       rd_data_valid
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= pkt_in.rd_valid;
        end
    end

    // hold the word until the next response
    always_ff @(posedge clk) begin
        if (pkt_in.rd_valid) begin
            rd_data <= pkt_in.rd_data;
        end
    end

    // only read packets ever pick up a response on the way
    a_valid_on_read : assert property (
        @(posedge clk) disable iff (!rst_n)
        pkt_in.rd_valid |-> (pkt_in.op == PKT_RD)
    );

endmodule

/* global_buffer.sv */
// Processor access path of the tiled global buffer.
// Requests enter at the west end and ride east through GLB_NUM_TILES tiles.
// Read latency is fixed at GLB_NUM_TILES+2 cycles from the sampling edge.
// Writes are strobed per byte; a later read of the same word sees the write.
// No back-pressure and no response path to the west.

`timescale 1ns/1ps

`include "glb_cfg.svh"

module global_buffer import glb_map_pkg::*; import glb_pkt_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // processor write
    input  logic       proc2glb_wr_en,
    input  strb_t      proc2glb_wr_strb,
    input  glb_addr_t  proc2glb_wr_addr,
    input  bank_data_t proc2glb_wr_data,

    // processor read
    input  logic       proc2glb_rd_en,
    input  glb_addr_t  proc2glb_rd_addr,
    output bank_data_t glb2proc_rd_data,
    output logic       glb2proc_rd_data_valid
);

    // pkt[0] from ingress, pkt[k+1] out of tile k, last one into egress
    glb_packet_if pkt [`GLB_NUM_TILES+1] ();

    glb_proc_ingress i_glb_proc_ingress (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (proc2glb_wr_en),
        .wr_strb (proc2glb_wr_strb),
        .wr_addr (proc2glb_wr_addr),
        .wr_data (proc2glb_wr_data),
        .rd_en   (proc2glb_rd_en),
        .rd_addr (proc2glb_rd_addr),
        .pkt_out (pkt[0].src)
    );

    for (genvar k = 0; k < `GLB_NUM_TILES; k++) begin : g_tile
        glb_tile #(
            .TILE_ID (k)
        ) i_glb_tile (
            .clk     (clk),
            .rst_n   (rst_n),
            .pkt_in  (pkt[k].dst),
            .pkt_out (pkt[k+1].src)
        );
    end

    glb_rd_egress i_glb_rd_egress (
        .clk           (clk),
        .rst_n         (rst_n),
        .pkt_in        (pkt[`GLB_NUM_TILES].dst),
        .rd_data       (glb2proc_rd_data),
        .rd_data_valid (glb2proc_rd_data_valid)
    );

endmodule

/* tb_global_buffer.sv */
// Testbench for the global buffer processor path.
// Inputs change on the falling clock edge, checks sample on the rising edge.
// Reference is a shadow byte memory plus a queue of expected reads.
// Partial-strobe writes only go to words that were fully written before,
// since bank contents are not reset.

`timescale 1ns/1ps

`include "glb_cfg.svh"

module tb_global_buffer import glb_map_pkg::*; import glb_pkt_pkg::*; ();

    localparam int NUM_TILES     = `GLB_NUM_TILES;
    localparam int NUM_BYTES     = `GLB_BANK_DATA_WIDTH / 8;
    localparam int ADDR_WIDTH    = `GLB_TILE_SEL_WIDTH + `GLB_BANK_ADDR_WIDTH;
    localparam int NUM_WORDS     = 2 ** ADDR_WIDTH;
    localparam int RD_LATENCY    = NUM_TILES + 2;
    localparam int DRAIN_TIMEOUT = 8 * RD_LATENCY;
    localparam int RANDOM_OPS    = 200;
    localparam logic [31:0] SEED = 32'h58b9_7bc4;

    logic       clk;
    logic       rst_n;
    logic       wr_en;
    strb_t      wr_strb;
    glb_addr_t  wr_addr;
    bank_data_t wr_data;
    logic       rd_en;
    glb_addr_t  rd_addr;
    bank_data_t rd_data;
    logic       rd_data_valid;

    // reference state
    logic [7:0] shadow [NUM_WORDS][NUM_BYTES];
    logic       written [NUM_WORDS];
    glb_addr_t  written_list [$];
    bank_data_t exp_data_q [$];
    int         exp_issue_q [$];
    int         q_count;
    bank_data_t head_data;
    int         head_issue;

    // rising edges seen so far
    int         cyc = 0;
    // response seen at the last rising edge, retired at the next falling one
    logic       pop_pending = 1'b0;
    logic       idle_check;
    int         fail_count;
    int         test_count;

    global_buffer i_global_buffer (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .proc2glb_wr_en         (wr_en),
        .proc2glb_wr_strb       (wr_strb),
        .proc2glb_wr_addr       (wr_addr),
        .proc2glb_wr_data       (wr_data),
        .proc2glb_rd_en         (rd_en),
        .proc2glb_rd_addr       (rd_addr),
        .glb2proc_rd_data       (rd_data),
        .glb2proc_rd_data_valid (rd_data_valid)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc         <= cyc + 1;
        pop_pending <= rd_data_valid;
    end

    a_resp_expected : assert property (
        @(posedge clk) rd_data_valid |-> (q_count != 0)
    ) else begin
        $display("t=%0t read response arrived with no read outstanding", $time);
        fail_count++;
    end

    a_resp_data : assert property (
        @(posedge clk) (rd_data_valid && q_count != 0) |-> (rd_data == head_data)
    ) else begin
        $display("[FAIL] t=%0t glb2proc_rd_data expected %h actual %h",
                 $time, $sampled(head_data), $sampled(rd_data));
        fail_count++;
    end

    // issue cycle is the edge count before the edge that samples rd_en
    a_resp_latency : assert property (
        @(posedge clk) (rd_data_valid && q_count != 0) |-> ((cyc - head_issue) == RD_LATENCY)
    ) else begin
        $display("[FAIL] t=%0t glb2proc_rd_data_valid latency expected %0d actual %0d",
                 $time, RD_LATENCY, $sampled(cyc) - $sampled(head_issue));
        fail_count++;
    end

    a_reset_quiet : assert property (
        @(posedge clk) (!rst_n && cyc >= 1) |-> !rd_data_valid
    ) else begin
        $display("t=%0t read valid came up while reset was held", $time);
        fail_count++;
    end

    a_idle_quiet : assert property (
        @(posedge clk) idle_check |-> !rd_data_valid
    ) else begin
        $display("t=%0t read valid came up during an idle stretch", $time);
        fail_count++;
    end

    function automatic void update_queue_head();
        q_count = exp_data_q.size();
        if (q_count > 0) begin
            head_data  = exp_data_q[0];
            head_issue = exp_issue_q[0];
        end
    endfunction

    function automatic void retire_response();
        if (pop_pending && exp_data_q.size() > 0) begin
            void'(exp_data_q.pop_front());
            void'(exp_issue_q.pop_front());
        end
        update_queue_head();
    endfunction

    function automatic int word_index(glb_addr_t a);
        return int'({a.tile, a.word});
    endfunction

    function automatic bank_data_t shadow_word(glb_addr_t a);
        bank_data_t w;
        int         idx;
        idx = word_index(a);
        for (int b = 0; b < NUM_BYTES; b++) begin
            w[b*8 +: 8] = shadow[idx][b];
        end
        return w;
    endfunction

    // byte merge, only strobed bytes take the new data
    function automatic void merge_into_shadow(glb_addr_t a, strb_t s, bank_data_t d);
        int idx;
        idx = word_index(a);
        for (int b = 0; b < NUM_BYTES; b++) begin
            if (s[b]) begin
                shadow[idx][b] = d[b*8 +: 8];
            end
        end
        if (!written[idx]) begin
            written[idx] = 1'b1;
            written_list.push_back(a);
        end
    endfunction

    function automatic bank_data_t random_data();
        return bank_data_t'({$urandom(), $urandom()});
    endfunction

    function automatic glb_addr_t random_addr(int tile);
        glb_addr_t a;
        a.tile = tile_sel_t'(tile);
        a.word = bank_addr_t'($urandom());
        return a;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        retire_response();
    endtask

    task automatic idle_cycles(int n);
        repeat (n) next_cycle();
    endtask

    task automatic issue_write(glb_addr_t a, strb_t s, bank_data_t d);
        wr_en   = 1'b1;
        rd_en   = 1'b0;
        wr_addr = a;
        wr_strb = s;
        wr_data = d;
        merge_into_shadow(a, s, d);
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic issue_read(glb_addr_t a);
        rd_en   = 1'b1;
        wr_en   = 1'b0;
        rd_addr = a;
        exp_data_q.push_back(shadow_word(a));
        exp_issue_q.push_back(cyc);
        update_queue_head();
        next_cycle();
        rd_en = 1'b0;
    endtask

    task automatic wait_reads_done();
        int waited;
        waited = 0;
        while (q_count != 0 && waited < DRAIN_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (q_count != 0) begin
            $display("t=%0t timeout, %0d read responses never arrived", $time, q_count);
            fail_count++;
            exp_data_q.delete();
            exp_issue_q.delete();
            update_queue_head();
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        test_count++;
        if (fail_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, fail_count - errors_before);
        end
    endtask

    initial begin
        int        errors_before;
        int        pick;
        glb_addr_t a;
        glb_addr_t addrs [$];
        strb_t     s;

        void'($urandom(SEED));
        clk        = 1'b0;
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        wr_strb    = '0;
        wr_addr    = '0;
        wr_data    = '0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        idle_check = 1'b0;
        fail_count = 0;
        test_count = 0;
        q_count    = 0;
        head_data  = '0;
        head_issue = 0;
        for (int i = 0; i < NUM_WORDS; i++) begin
            written[i] = 1'b0;
        end

        // 1: reset for 8 cycles, then 20 quiet cycles
        errors_before = fail_count;
        idle_cycles(8);
        rst_n      = 1'b1;
        idle_check = 1'b1;
        idle_cycles(20);
        idle_check = 1'b0;
        finish_test("reset and idle", errors_before);

        // 2: one full word per tile, read back after the writes
        errors_before = fail_count;
        for (int t = 0; t < NUM_TILES; t++) begin
            a = random_addr(t);
            addrs.push_back(a);
            issue_write(a, '1, random_data());
        end
        idle_cycles(RD_LATENCY);
        foreach (addrs[i]) begin
            issue_read(addrs[i]);
        end
        wait_reads_done();
        finish_test("full-strobe write then read", errors_before);

        // 3: full write, partial overwrite, read
        errors_before = fail_count;
        for (int i = 0; i < 2 * NUM_TILES; i++) begin
            a = random_addr(i % NUM_TILES);
            issue_write(a, '1, random_data());
            issue_write(a, strb_t'($urandom()), random_data());
            issue_read(a);
        end
        wait_reads_done();
        finish_test("partial strobe merge", errors_before);

        // 4: reads on every cycle, tile changes each time
        errors_before = fail_count;
        addrs.delete();
        for (int i = 0; i < 2 * NUM_TILES; i++) begin
            a.tile = tile_sel_t'(i % NUM_TILES);
            a.word = bank_addr_t'(128 + i);
            addrs.push_back(a);
            issue_write(a, '1, random_data());
        end
        idle_cycles(2);
        foreach (addrs[i]) begin
            issue_read(addrs[i]);
        end
        wait_reads_done();
        finish_test("back-to-back reads", errors_before);

        // 5: read of the same word right behind its write
        errors_before = fail_count;
        for (int t = 0; t < NUM_TILES; t++) begin
            a = random_addr(t);
            issue_write(a, '1, random_data());
            issue_write(a, '1, random_data());
            issue_read(a);
        end
        wait_reads_done();
        finish_test("read right after write", errors_before);

        // 6: random mix, reads only hit words already written
        errors_before = fail_count;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            pick = $urandom_range(0, 9);
            if (pick == 0) begin
                idle_cycles(1);
            end
            if (pick < 5 || written_list.size() == 0) begin
                a = random_addr($urandom_range(0, NUM_TILES - 1));
                s = written[word_index(a)] ? strb_t'($urandom()) : '1;
                issue_write(a, s, random_data());
            end else begin
                issue_read(written_list[$urandom_range(0, written_list.size() - 1)]);
            end
        end
        wait_reads_done();
        idle_check = 1'b1;
        idle_cycles(RD_LATENCY);
        idle_check = 1'b0;
        finish_test("random traffic", errors_before);

        $display("tests run %0d, errors %0d", test_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+.
glb_map_pkg.sv
glb_pkt_pkg.sv
glb_packet_if.sv
glb_proc_ingress.sv
glb_tile.sv
glb_rd_egress.sv
global_buffer.sv
tb_global_buffer.sv

/* run.sh */
#!/bin/sh
# Builds the global buffer testbench with Verilator and runs it.
# The run counts as passed only if the pass line shows up in the output.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_global_buffer -f all.f

out=$(./obj_dir/Vtb_global_buffer)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
